//--- include/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Number of lines in the instruction cache
`define MEM_ICACHE_LINES 16

// Base of the core-local timer
`define MEM_CLINT_BASE 32'h0200_0000

// Address bits that pick the 64 KiB timer window
`define MEM_CLINT_MASK 32'hffff_0000

// Word offsets inside the timer window
`define MEM_CLINT_MTIME_LO 32'h0000_0000
`define MEM_CLINT_MTIME_HI 32'h0000_0004

`endif

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module core_mem_top_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vcore_mem_top_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- src/bus_pkg.sv
`default_nettype none

package bus_pkg;

	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_exokay = 2'b01,
		resp_slverr = 2'b10,
		resp_decerr = 2'b11
	} resp_e;

	typedef struct packed {
		core_pkg::addr_t addr;
		logic [2:0]      size; // Same layout on AR and AW
	} ar_t;

	typedef struct packed {
		core_pkg::word_t data;
		logic [3:0]      strb;
	} w_t;

	typedef struct packed {
		core_pkg::word_t data;
		resp_e           resp;
	} r_t;

endpackage

`default_nettype wire

//--- src/clint.sv
`timescale 1ns/1ns
`default_nettype none
`include "mem_params.svh"

module clint (
	input  logic            clock,
	input  logic            rst_n,
	input  logic            arvalid,
	input  core_pkg::addr_t araddr,
	output logic            arready,
	output logic            rvalid,
	output bus_pkg::r_t     rdata,
	input  logic            rready
);

	logic [63:0]     mtime;
	core_pkg::addr_t offset;

	assign arready = 1'b1; // A register read never stalls
	assign offset = araddr & ~`MEM_CLINT_MASK;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
			rvalid <= 1'b0;
		end else begin
			mtime <= mtime + 64'd1;
			if (arvalid && arready) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (arvalid && arready) begin
			case (offset)
				`MEM_CLINT_MTIME_LO: begin
					rdata.data <= mtime[31:0];
					rdata.resp <= bus_pkg::resp_okay;
				end
				`MEM_CLINT_MTIME_HI: begin
					rdata.data <= mtime[63:32];
					rdata.resp <= bus_pkg::resp_okay;
				end
				default: begin
					rdata.data <= '0;
					rdata.resp <= bus_pkg::resp_decerr; // Nothing else lives in the window
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/core_mem_top.sv
`timescale 1ns/1ns
`default_nettype none

module core_mem_top (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               fetch_valid,
	input  core_pkg::addr_t    fetch_pc,
	output logic               fetch_ready,
	output logic               inst_valid,
	output core_pkg::word_t    inst,
	output bus_pkg::resp_e     inst_resp,
	input  logic               fence_i,
	input  logic               lsu_valid,
	input  core_pkg::lsu_req_t lsu_req,
	output logic               lsu_ready,
	output logic               lsu_done,
	output core_pkg::word_t    lsu_rdata,
	output bus_pkg::resp_e     lsu_resp,
	output bus_pkg::ar_t       m_ar,
	output logic               m_arvalid,
	input  logic               m_arready,
	input  bus_pkg::r_t        m_r,
	input  logic               m_rvalid,
	output logic               m_rready,
	output bus_pkg::ar_t       m_aw,
	output logic               m_awvalid,
	input  logic               m_awready,
	output bus_pkg::w_t        m_w,
	output logic               m_wvalid,
	input  logic               m_wready,
	input  bus_pkg::resp_e     m_bresp,
	input  logic               m_bvalid,
	output logic               m_bready
);

	bus_pkg::ar_t    ifu_ar;
	bus_pkg::ar_t    lsu_ar;
	bus_pkg::ar_t    lsu_aw;
	bus_pkg::r_t     ifu_r;
	bus_pkg::r_t     lsu_r;
	bus_pkg::r_t     clint_r;
	bus_pkg::w_t     lsu_w;
	bus_pkg::resp_e  lsu_bresp;
	core_pkg::addr_t clint_araddr;
	core_pkg::addr_t cache_addr;
	core_pkg::addr_t fill_addr;
	core_pkg::word_t cache_data;
	core_pkg::word_t fill_data;
	logic            ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
	logic            lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
	logic            lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready;
	logic            lsu_bvalid, lsu_bready;
	logic            clint_arvalid, clint_arready, clint_rvalid, clint_rready;
	logic            cache_hit;
	logic            fill_valid;

	ifu my_ifu (
		.clock(clock), .rst_n(rst_n),
		.fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_ready(fetch_ready),
		.inst_valid(inst_valid), .inst(inst), .inst_resp(inst_resp),
		.cache_addr(cache_addr), .cache_hit(cache_hit), .cache_data(cache_data),
		.fill_valid(fill_valid), .fill_addr(fill_addr), .fill_data(fill_data),
		.ar(ifu_ar), .arvalid(ifu_arvalid), .arready(ifu_arready),
		.r(ifu_r), .rvalid(ifu_rvalid), .rready(ifu_rready)
	);

	icache my_icache (
		.clock(clock), .rst_n(rst_n),
		.lookup_addr(cache_addr), .hit(cache_hit), .rdata(cache_data),
		.fill_valid(fill_valid), .fill_addr(fill_addr), .fill_data(fill_data),
		.invalidate(fence_i)
	);

	lsu my_lsu (
		.clock(clock), .rst_n(rst_n),
		.lsu_valid(lsu_valid), .lsu_req(lsu_req), .lsu_ready(lsu_ready),
		.lsu_done(lsu_done), .lsu_rdata(lsu_rdata), .lsu_resp(lsu_resp),
		.ar(lsu_ar), .arvalid(lsu_arvalid), .arready(lsu_arready),
		.r(lsu_r), .rvalid(lsu_rvalid), .rready(lsu_rready),
		.aw(lsu_aw), .awvalid(lsu_awvalid), .awready(lsu_awready),
		.w(lsu_w), .wvalid(lsu_wvalid), .wready(lsu_wready),
		.bresp(lsu_bresp), .bvalid(lsu_bvalid), .bready(lsu_bready)
	);

	xbar my_xbar (
		.clock(clock), .rst_n(rst_n),
		.ifu_ar(ifu_ar), .ifu_arvalid(ifu_arvalid), .ifu_arready(ifu_arready),
		.ifu_r(ifu_r), .ifu_rvalid(ifu_rvalid), .ifu_rready(ifu_rready),
		.lsu_ar(lsu_ar), .lsu_arvalid(lsu_arvalid), .lsu_arready(lsu_arready),
		.lsu_r(lsu_r), .lsu_rvalid(lsu_rvalid), .lsu_rready(lsu_rready),
		.lsu_aw(lsu_aw), .lsu_awvalid(lsu_awvalid), .lsu_awready(lsu_awready),
		.lsu_w(lsu_w), .lsu_wvalid(lsu_wvalid), .lsu_wready(lsu_wready),
		.lsu_bresp(lsu_bresp), .lsu_bvalid(lsu_bvalid), .lsu_bready(lsu_bready),
		.clint_araddr(clint_araddr), .clint_arvalid(clint_arvalid),
		.clint_arready(clint_arready), .clint_r(clint_r),
		.clint_rvalid(clint_rvalid), .clint_rready(clint_rready),
		.m_ar(m_ar), .m_arvalid(m_arvalid), .m_arready(m_arready),
		.m_r(m_r), .m_rvalid(m_rvalid), .m_rready(m_rready),
		.m_aw(m_aw), .m_awvalid(m_awvalid), .m_awready(m_awready),
		.m_w(m_w), .m_wvalid(m_wvalid), .m_wready(m_wready),
		.m_bresp(m_bresp), .m_bvalid(m_bvalid), .m_bready(m_bready)
	);

	clint my_clint (
		.clock(clock), .rst_n(rst_n),
		.arvalid(clint_arvalid), .araddr(clint_araddr), .arready(clint_arready),
		.rvalid(clint_rvalid), .rdata(clint_r), .rready(clint_rready)
	);

endmodule

`default_nettype wire

//--- src/core_pkg.sv
`default_nettype none

package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;

	typedef enum logic [3:0] {
		mem_lb  = 4'b0000, // Bit 3 marks a store and bits 2:0 hold funct3
		mem_lh  = 4'b0001,
		mem_lw  = 4'b0010,
		mem_lbu = 4'b0100,
		mem_lhu = 4'b0101,
		mem_sb  = 4'b1000,
		mem_sh  = 4'b1001,
		mem_sw  = 4'b1010
	} mem_op_e;

	typedef struct packed {
		addr_t   addr;
		mem_op_e op;
		word_t   wdata;
	} lsu_req_t;

	typedef enum logic [2:0] {
		lsu_idle,
		lsu_read,
		lsu_read_resp,
		lsu_write,
		lsu_write_resp
	} lsu_state_e;

	typedef enum logic [1:0] {
		ifu_idle,
		ifu_hit,
		ifu_request,
		ifu_response
	} ifu_state_e;

endpackage

`default_nettype wire

//--- src/icache.sv
`timescale 1ns/1ns
`default_nettype none
`include "mem_params.svh"

module icache (
	input  logic            clock,
	input  logic            rst_n,
	input  core_pkg::addr_t lookup_addr,
	output logic            hit,
	output core_pkg::word_t rdata,
	input  logic            fill_valid,
	input  core_pkg::addr_t fill_addr,
	input  core_pkg::word_t fill_data,
	input  logic            invalidate
);

	localparam int LINES   = `MEM_ICACHE_LINES;
	localparam int INDEX_W = $clog2(LINES);
	localparam int TAG_W   = 32 - INDEX_W - 2;

	logic [TAG_W-1:0]   tags [LINES];
	core_pkg::word_t    data [LINES];
	logic [LINES-1:0]   valid;
	logic [INDEX_W-1:0] lookup_index;
	logic [INDEX_W-1:0] fill_index;
	logic [TAG_W-1:0]   lookup_tag;
	logic [TAG_W-1:0]   fill_tag;

	// One word per line so the index starts above the byte offset
	assign lookup_index = lookup_addr[INDEX_W+1:2];
	assign lookup_tag = lookup_addr[31:INDEX_W+2];
	assign fill_index = fill_addr[INDEX_W+1:2];
	assign fill_tag = fill_addr[31:INDEX_W+2];

	assign hit = valid[lookup_index] && (tags[lookup_index] == lookup_tag);
	assign rdata = data[lookup_index];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (invalidate) begin
			valid <= '0; // A fill in the same cycle is dropped
		end else if (fill_valid) begin
			valid[fill_index] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (fill_valid) begin
			tags[fill_index] <= fill_tag;
			data[fill_index] <= fill_data;
		end
	end

endmodule

`default_nettype wire

//--- src/ifu.sv
`timescale 1ns/1ns
`default_nettype none

module ifu (
	input  logic            clock,
	input  logic            rst_n,
	input  logic            fetch_valid,
	input  core_pkg::addr_t fetch_pc,
	output logic            fetch_ready,
	output logic            inst_valid,
	output core_pkg::word_t inst,
	output bus_pkg::resp_e  inst_resp,
	output core_pkg::addr_t cache_addr,
	input  logic            cache_hit,
	input  core_pkg::word_t cache_data,
	output logic            fill_valid,
	output core_pkg::addr_t fill_addr,
	output core_pkg::word_t fill_data,
	output bus_pkg::ar_t    ar,
	output logic            arvalid,
	input  logic            arready,
	input  bus_pkg::r_t     r,
	input  logic            rvalid,
	output logic            rready
);

	core_pkg::ifu_state_e state;
	core_pkg::addr_t      pc;

	assign fetch_ready = (state == core_pkg::ifu_idle);
	assign cache_addr = pc;
	assign ar = '{addr: pc, size: 3'd2};
	assign arvalid = (state == core_pkg::ifu_request);
	assign rready = (state == core_pkg::ifu_response);

	// Hits answer from the cache and misses straight from the bus
	assign inst_valid = (state == core_pkg::ifu_hit && cache_hit) ||
		(state == core_pkg::ifu_response && rvalid);
	assign inst = (state == core_pkg::ifu_hit) ? cache_data : r.data;
	assign inst_resp = (state == core_pkg::ifu_hit) ? bus_pkg::resp_okay : r.resp;

	assign fill_valid = rready && rvalid && (r.resp == bus_pkg::resp_okay); // Failed reads stay out
	assign fill_addr = pc;
	assign fill_data = r.data;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= core_pkg::ifu_idle;
		end else begin
			case (state)
				core_pkg::ifu_idle: if (fetch_valid) state <= core_pkg::ifu_hit;
				core_pkg::ifu_hit: state <= cache_hit ? core_pkg::ifu_idle : core_pkg::ifu_request;
				core_pkg::ifu_request: if (arready) state <= core_pkg::ifu_response;
				default: if (rvalid) state <= core_pkg::ifu_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_valid && fetch_ready) begin
			pc <= fetch_pc;
		end
	end

endmodule

`default_nettype wire

//--- src/lsu.sv
`timescale 1ns/1ns
`default_nettype none

module lsu (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              lsu_valid,
	input  core_pkg::lsu_req_t lsu_req,
	output logic              lsu_ready,
	output logic              lsu_done,
	output core_pkg::word_t   lsu_rdata,
	output bus_pkg::resp_e    lsu_resp,
	output bus_pkg::ar_t      ar,
	output logic              arvalid,
	input  logic              arready,
	input  bus_pkg::r_t       r,
	input  logic              rvalid,
	output logic              rready,
	output bus_pkg::ar_t      aw,
	output logic              awvalid,
	input  logic              awready,
	output bus_pkg::w_t       w,
	output logic              wvalid,
	input  logic              wready,
	input  bus_pkg::resp_e    bresp,
	input  logic              bvalid,
	output logic              bready
);

	core_pkg::lsu_state_e state;
	core_pkg::lsu_req_t   req;
	logic                 aw_done;
	logic                 w_done;
	logic [4:0]           shamt;
	logic [3:0]           mask;
	core_pkg::word_t      load_word;
	core_pkg::word_t      load_data;

	assign shamt = {req.addr[1:0], 3'b000};
	assign lsu_ready = (state == core_pkg::lsu_idle);

	assign ar = '{addr: req.addr, size: {1'b0, req.op[1:0]}}; // funct3 low bits give the size
	assign aw = ar;
	assign arvalid = (state == core_pkg::lsu_read);
	assign rready = (state == core_pkg::lsu_read_resp);
	assign awvalid = (state == core_pkg::lsu_write) && !aw_done;
	assign wvalid = (state == core_pkg::lsu_write) && !w_done;
	assign bready = (state == core_pkg::lsu_write_resp);

	always_comb begin
		case (req.op[1:0])
			2'b00: mask = 4'b0001;
			2'b01: mask = 4'b0011;
			default: mask = 4'b1111;
		endcase
	end

	assign w = '{data: req.wdata << shamt, strb: mask << req.addr[1:0]};

	// Move the addressed byte lane down before extending
	assign load_word = r.data >> shamt;

	always_comb begin
		case (req.op)
			core_pkg::mem_lb: load_data = {{24{load_word[7]}}, load_word[7:0]};
			core_pkg::mem_lh: load_data = {{16{load_word[15]}}, load_word[15:0]};
			core_pkg::mem_lbu: load_data = {24'd0, load_word[7:0]};
			core_pkg::mem_lhu: load_data = {16'd0, load_word[15:0]};
			default: load_data = load_word;
		endcase
	end

	assign lsu_done = (rready && rvalid) || (bready && bvalid);
	assign lsu_rdata = rready ? load_data : '0;
	assign lsu_resp = rready ? r.resp : bresp;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= core_pkg::lsu_idle;
			aw_done <= 1'b0;
			w_done <= 1'b0;
		end else begin
			case (state)
				core_pkg::lsu_idle: begin
					aw_done <= 1'b0;
					w_done <= 1'b0;
					if (lsu_valid) begin
						state <= lsu_req.op[3] ? core_pkg::lsu_write : core_pkg::lsu_read;
					end
				end
				core_pkg::lsu_read: if (arready) state <= core_pkg::lsu_read_resp;
				core_pkg::lsu_read_resp: if (rvalid) state <= core_pkg::lsu_idle;
				core_pkg::lsu_write: begin
					aw_done <= aw_done || awready; // AW and W may complete in either order
					w_done <= w_done || wready;
					if ((aw_done || awready) && (w_done || wready)) begin
						state <= core_pkg::lsu_write_resp;
					end
				end
				default: if (bvalid) state <= core_pkg::lsu_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (lsu_valid && lsu_ready) begin
			req <= lsu_req;
		end
	end

endmodule

`default_nettype wire

//--- src/xbar.sv
`timescale 1ns/1ns
`default_nettype none
`include "mem_params.svh"

module xbar (
	input  logic            clock,
	input  logic            rst_n,
	input  bus_pkg::ar_t    ifu_ar,
	input  logic            ifu_arvalid,
	output logic            ifu_arready,
	output bus_pkg::r_t     ifu_r,
	output logic            ifu_rvalid,
	input  logic            ifu_rready,
	input  bus_pkg::ar_t    lsu_ar,
	input  logic            lsu_arvalid,
	output logic            lsu_arready,
	output bus_pkg::r_t     lsu_r,
	output logic            lsu_rvalid,
	input  logic            lsu_rready,
	input  bus_pkg::ar_t    lsu_aw,
	input  logic            lsu_awvalid,
	output logic            lsu_awready,
	input  bus_pkg::w_t     lsu_w,
	input  logic            lsu_wvalid,
	output logic            lsu_wready,
	output bus_pkg::resp_e  lsu_bresp,
	output logic            lsu_bvalid,
	input  logic            lsu_bready,
	output core_pkg::addr_t clint_araddr,
	output logic            clint_arvalid,
	input  logic            clint_arready,
	input  bus_pkg::r_t     clint_r,
	input  logic            clint_rvalid,
	output logic            clint_rready,
	output bus_pkg::ar_t    m_ar,
	output logic            m_arvalid,
	input  logic            m_arready,
	input  bus_pkg::r_t     m_r,
	input  logic            m_rvalid,
	output logic            m_rready,
	output bus_pkg::ar_t    m_aw,
	output logic            m_awvalid,
	input  logic            m_awready,
	output bus_pkg::w_t     m_w,
	output logic            m_wvalid,
	input  logic            m_wready,
	input  bus_pkg::resp_e  m_bresp,
	input  logic            m_bvalid,
	output logic            m_bready
);

	typedef enum logic [1:0] {grant_none, grant_ifu, grant_lsu} grant_e;

	grant_e       grant_q;
	grant_e       grant;
	logic         target_q; // High while the granted read sits at the CLINT
	logic         to_clint;
	bus_pkg::ar_t sel_ar;
	logic         sel_arvalid;
	logic         sel_arready;
	bus_pkg::r_t  src_r;
	logic         src_rvalid;
	logic         src_rready;

	always_comb begin
		grant = grant_q;
		if (grant_q == grant_none) begin
			if (lsu_arvalid) begin
				grant = grant_lsu; // Loads go ahead of fetches
			end else if (ifu_arvalid) begin
				grant = grant_ifu;
			end
		end
	end

	assign sel_ar = (grant == grant_lsu) ? lsu_ar : ifu_ar;
	assign sel_arvalid = (grant == grant_lsu) ? lsu_arvalid : (grant == grant_ifu) && ifu_arvalid;
	assign to_clint = (sel_ar.addr & `MEM_CLINT_MASK) == `MEM_CLINT_BASE;
	assign sel_arready = to_clint ? clint_arready : m_arready;

	assign m_ar = sel_ar;
	assign m_arvalid = sel_arvalid && !to_clint;
	assign clint_araddr = sel_ar.addr;
	assign clint_arvalid = sel_arvalid && to_clint;
	assign lsu_arready = (grant == grant_lsu) && sel_arready;
	assign ifu_arready = (grant == grant_ifu) && sel_arready;

	assign src_r = target_q ? clint_r : m_r;
	assign src_rvalid = (grant_q != grant_none) && (target_q ? clint_rvalid : m_rvalid);
	assign src_rready = (grant_q == grant_lsu) ? lsu_rready : (grant_q == grant_ifu) && ifu_rready;
	assign m_rready = !target_q && src_rready;
	assign clint_rready = target_q && src_rready;
	assign ifu_r = src_r;
	assign lsu_r = src_r;
	assign ifu_rvalid = (grant_q == grant_ifu) && src_rvalid;
	assign lsu_rvalid = (grant_q == grant_lsu) && src_rvalid;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			grant_q <= grant_none;
			target_q <= 1'b0;
		end else if (grant_q == grant_none) begin
			grant_q <= grant;
			target_q <= to_clint;
		end else if (src_rvalid && src_rready) begin
			grant_q <= grant_none;
		end
	end

	// Only the LSU writes and it always goes to the master port
	assign m_aw = lsu_aw;
	assign m_awvalid = lsu_awvalid;
	assign lsu_awready = m_awready;
	assign m_w = lsu_w;
	assign m_wvalid = lsu_wvalid;
	assign lsu_wready = m_wready;
	assign lsu_bresp = m_bresp;
	assign lsu_bvalid = m_bvalid;
	assign m_bready = lsu_bready;

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
src/core_pkg.sv
src/bus_pkg.sv
src/clint.sv
src/icache.sv
src/ifu.sv
src/lsu.sv
src/xbar.sv
src/core_mem_top.sv
testbench/core_mem_top_tb.sv

//--- testbench/core_mem_top_tb.sv
`timescale 1ns/1ns
`default_nettype none

module core_mem_top_tb;

	localparam int FIELDS = 6; // kind, addr, wdata, expected data, expected resp, AR delta
	localparam int MAX_OPS = 64;
	localparam int CYCLES_PER_OP = 20;

	logic               clock;
	logic               rst_n;
	logic               fetch_valid;
	core_pkg::addr_t    fetch_pc;
	logic               fetch_ready;
	logic               inst_valid;
	core_pkg::word_t    inst;
	bus_pkg::resp_e     inst_resp;
	logic               fence_i;
	logic               lsu_valid;
	core_pkg::lsu_req_t lsu_req;
	logic               lsu_ready;
	logic               lsu_done;
	core_pkg::word_t    lsu_rdata;
	bus_pkg::resp_e     lsu_resp;
	bus_pkg::ar_t       m_ar;
	logic               m_arvalid;
	logic               m_arready;
	bus_pkg::r_t        m_r;
	logic               m_rvalid;
	logic               m_rready;
	bus_pkg::ar_t       m_aw;
	logic               m_awvalid;
	logic               m_awready;
	bus_pkg::w_t        m_w;
	logic               m_wvalid;
	logic               m_wready;
	bus_pkg::resp_e     m_bresp;
	logic               m_bvalid;
	logic               m_bready;

	logic [31:0]     trace [512];
	core_pkg::word_t mem [64];
	core_pkg::addr_t ar_log [$]; // Master AR addresses in the order they were accepted
	logic [2:0]      ar_sizes [$];
	logic [2:0]      aw_sizes [$];
	logic [15:0]     lfsr = 16'd9;
	int              cycles = 0;
	int              cycle_limit = 0;

	core_mem_top UUT (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: the trace was still running after %0d cycles", cycles);
			$display("ERRORS FOUND");
			$fatal(1, "Timeout");
		end
	end

	// Two LFSR bits give a delay of 0 to 3 cycles
	function automatic int random_delay();
		int value;
		value = 0;
		for (int i = 0; i < 2; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
		end
		return value;
	endfunction

	// AXI size code for the number of bytes an op moves
	function automatic logic [2:0] access_size(input core_pkg::mem_op_e op);
		case (op)
			core_pkg::mem_lb, core_pkg::mem_lbu, core_pkg::mem_sb: return 3'd0;
			core_pkg::mem_lh, core_pkg::mem_lhu, core_pkg::mem_sh: return 3'd1;
			default: return 3'd2;
		endcase
	endfunction

	function automatic void apply_write(input core_pkg::addr_t addr, input bus_pkg::w_t beat);
		core_pkg::word_t bit_mask;
		bit_mask = {{8{beat.strb[3]}}, {8{beat.strb[2]}}, {8{beat.strb[1]}}, {8{beat.strb[0]}}};
		mem[addr[7:2]] = (mem[addr[7:2]] & ~bit_mask) | (beat.data & bit_mask);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// The first new read carries the op's size and any read after it is a word fetch
	task automatic verify_read_sizes(input int first, input logic [2:0] size);
		for (int i = first; i < ar_sizes.size(); i++) begin
			check_value("m_ar.size", 32'(ar_sizes[i]), (i == first) ? 32'(size) : 32'd2);
		end
	endtask

	// Responses are sampled 1 ns after the falling edge, once the inputs have settled
	task automatic fetch_inst(input core_pkg::addr_t pc, output core_pkg::word_t data,
		output bus_pkg::resp_e resp, output int latency);
		@(negedge clock);
		fetch_valid = 1'b1;
		fetch_pc = pc;
		#1;
		while (!fetch_ready) begin
			@(negedge clock);
			#1;
		end
		@(negedge clock);
		fetch_valid = 1'b0;
		latency = 1;
		#1;
		while (!inst_valid) begin
			@(negedge clock);
			#1;
			latency++;
		end
		data = inst;
		resp = inst_resp;
	endtask

	task automatic lsu_access(input core_pkg::mem_op_e op, input core_pkg::addr_t addr,
		input core_pkg::word_t wdata, output core_pkg::word_t data, output bus_pkg::resp_e resp);
		@(negedge clock);
		lsu_valid = 1'b1;
		lsu_req = '{addr: addr, op: op, wdata: wdata};
		#1;
		while (!lsu_ready) begin
			@(negedge clock);
			#1;
		end
		@(negedge clock);
		lsu_valid = 1'b0;
		#1;
		while (!lsu_done) begin
			@(negedge clock);
			#1;
		end
		data = lsu_rdata;
		resp = lsu_resp;
	endtask

	task automatic pulse_fence();
		@(negedge clock);
		fence_i = 1'b1;
		@(negedge clock);
		fence_i = 1'b0;
	endtask

	// AXI-lite slave with one read and one write in flight and random stalls
	initial begin : axi_memory
		core_pkg::addr_t r_addr;
		core_pkg::addr_t aw_addr;
		bus_pkg::w_t     w_beat;
		logic            r_busy;
		logic            aw_got;
		logic            w_got;
		logic            b_busy;
		int              ar_wait;
		int              r_wait;
		int              aw_wait;
		int              w_wait;
		int              b_wait;
		for (int i = 0; i < 64; i++) begin
			mem[i[5:0]] = 32'(i) * 32'h0101_0101 + 32'h1000;
		end
		r_addr = '0;
		aw_addr = '0;
		w_beat = '0;
		r_busy = 1'b0;
		aw_got = 1'b0;
		w_got = 1'b0;
		b_busy = 1'b0;
		m_arready = 1'b0;
		m_r = '0;
		m_rvalid = 1'b0;
		m_awready = 1'b0;
		m_wready = 1'b0;
		m_bresp = bus_pkg::resp_okay;
		m_bvalid = 1'b0;
		ar_wait = random_delay();
		r_wait = random_delay();
		aw_wait = random_delay();
		w_wait = random_delay();
		b_wait = random_delay();
		forever begin
			@(negedge clock);
			m_arready = !r_busy && ar_wait == 0;
			m_rvalid = r_busy && r_wait == 0;
			m_r = '{data: mem[r_addr[7:2]], resp: bus_pkg::resp_okay};
			m_awready = !aw_got && aw_wait == 0;
			m_wready = !w_got && w_wait == 0;
			m_bvalid = b_busy && b_wait == 0;
			#1;
			if (m_arvalid && m_arready) begin
				ar_log.push_back(m_ar.addr);
				ar_sizes.push_back(m_ar.size);
				r_addr = m_ar.addr;
				r_busy = 1'b1;
				r_wait = random_delay();
				ar_wait = random_delay();
			end else if (m_arvalid && ar_wait > 0) begin
				ar_wait--;
			end
			if (m_rvalid && m_rready) begin
				r_busy = 1'b0;
			end else if (r_busy && r_wait > 0) begin
				r_wait--;
			end
			if (m_awvalid && m_awready) begin
				aw_got = 1'b1;
				aw_addr = m_aw.addr;
				aw_sizes.push_back(m_aw.size);
			end else if (m_awvalid && aw_wait > 0) begin
				aw_wait--;
			end
			if (m_wvalid && m_wready) begin
				w_got = 1'b1;
				w_beat = m_w;
			end else if (m_wvalid && w_wait > 0) begin
				w_wait--;
			end
			if (aw_got && w_got && !b_busy) begin
				apply_write(aw_addr, w_beat);
				b_busy = 1'b1;
				b_wait = random_delay();
			end else if (m_bvalid && m_bready) begin
				b_busy = 1'b0;
				aw_got = 1'b0;
				w_got = 1'b0;
				aw_wait = random_delay();
				w_wait = random_delay();
			end else if (b_busy && b_wait > 0) begin
				b_wait--;
			end
		end
	end

	initial begin : run_trace
		int              ops;
		int              base;
		int              ar_before;
		int              aw_before;
		int              latency;
		logic [31:0]     kind;
		core_pkg::addr_t addr;
		core_pkg::word_t wdata;
		core_pkg::word_t exp_data;
		logic [31:0]     exp_resp;
		logic [31:0]     exp_ar;
		logic [2:0]      exp_size;
		core_pkg::word_t got_data;
		core_pkg::word_t got_inst;
		core_pkg::word_t last_mtime;
		bus_pkg::resp_e  got_resp;
		bus_pkg::resp_e  got_iresp;
		rst_n = 1'b0;
		fetch_valid = 1'b0;
		fetch_pc = '0;
		fence_i = 1'b0;
		lsu_valid = 1'b0;
		lsu_req = '0;
		last_mtime = '0;
		$readmemh("testbench/mem_trace.txt", trace);
		ops = 0;
		base = 0;
		while (ops < MAX_OPS && trace[base[8:0]] != 32'hff) begin
			ops++;
			base = FIELDS * ops;
		end
		if (ops == 0) begin
			$display("The trace file holds no operations");
			$display("ERRORS FOUND");
			$fatal(1, "Empty trace");
		end
		cycle_limit = ops * CYCLES_PER_OP;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;

		for (int n = 0; n < ops; n++) begin
			base = FIELDS * n;
			kind = trace[base[8:0]];
			addr = trace[9'(base + 1)];
			wdata = trace[9'(base + 2)];
			exp_data = trace[9'(base + 3)];
			exp_resp = trace[9'(base + 4)];
			exp_ar = trace[9'(base + 5)];
			ar_before = ar_log.size();
			aw_before = aw_sizes.size();
			exp_size = 3'd2;
			case (kind[7:0])
				8'h00, 8'h01, 8'h02, 8'h04, 8'h05, 8'h08, 8'h09, 8'h0a: begin
					exp_size = access_size(core_pkg::mem_op_e'(kind[3:0]));
					lsu_access(core_pkg::mem_op_e'(kind[3:0]), addr, wdata, got_data, got_resp);
					check_value("lsu_rdata", got_data, exp_data);
					check_value("lsu_resp", 32'(got_resp), exp_resp);
					check_value("master AW count", aw_sizes.size() - aw_before, 32'(kind[3]));
					if (kind[3]) begin
						check_value("m_aw.size", 32'(aw_sizes[aw_before]), 32'(exp_size));
					end
				end
				8'h10: begin
					fetch_inst(addr, got_inst, got_iresp, latency);
					check_value("inst", got_inst, exp_data);
					check_value("inst_resp", 32'(got_iresp), exp_resp);
					if (exp_ar == 0) begin
						check_value("hit latency", latency, 1); // Cache hits answer in one cycle
					end
				end
				8'h11: pulse_fence();
				8'h12: begin
					lsu_access(core_pkg::mem_lw, addr, '0, got_data, got_resp);
					check_value("lsu_resp", 32'(got_resp), exp_resp);
					assert (got_data > last_mtime) else begin
						$display("CHECK FAILED lsu_rdata: got %h expected above %h",
							got_data, last_mtime);
						$display("ERRORS FOUND");
						$fatal(1, "Timer did not advance");
					end
					last_mtime = got_data;
				end
				8'h20, 8'h21, 8'h22, 8'h24, 8'h25: begin
					exp_size = access_size(core_pkg::mem_op_e'(kind[3:0]));
					fork
						fetch_inst(wdata, got_inst, got_iresp, latency);
						lsu_access(core_pkg::mem_op_e'(kind[3:0]), addr, '0, got_data, got_resp);
					join
					check_value("inst", got_inst, mem[wdata[7:2]]);
					check_value("lsu_rdata", got_data, exp_data);
					check_value("first master AR address", ar_log[ar_before], addr);
				end
				default: begin
					$display("Unknown operation kind %h on trace line %0d", kind, n);
					$display("ERRORS FOUND");
					$fatal(1, "Bad trace");
				end
			endcase
			check_value("master AR count", ar_log.size() - ar_before, exp_ar);
			verify_read_sizes(ar_before, exp_size);
		end

		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/mem_trace.txt
// kind addr wdata expected_data expected_resp master_ar_delta
// kind: 0-a LSU op, 10 fetch, 11 fence.i, 12 timer low read, 2x fetch at wdata with load op x, ff end
10 00000010 00000000 04041404 0 1
10 00000010 00000000 04041404 0 0
11 00000000 00000000 00000000 0 0
10 00000010 00000000 04041404 0 1
10 00000050 00000000 14142414 0 1 // Same cache line as 0x10
10 00000010 00000000 04041404 0 1
10 00000050 00000000 14142414 0 1
10 00000050 00000000 14142414 0 0
8 00000080 123456aa 00000000 0 0
8 00000081 1234565b 00000000 0 0
2 00000080 00000000 20205baa 0 1
8 00000082 000000cc 00000000 0 0
8 00000083 ffffff9d 00000000 0 0
2 00000080 00000000 9dcc5baa 0 1
9 00000084 7777beef 00000000 0 0
9 00000086 0000c0de 00000000 0 0
2 00000084 00000000 c0debeef 0 1
a 00000088 8f7ea5c3 00000000 0 0
2 00000088 00000000 8f7ea5c3 0 1
0 00000088 00000000 ffffffc3 0 1
0 00000089 00000000 ffffffa5 0 1
0 0000008a 00000000 0000007e 0 1
0 0000008b 00000000 ffffff8f 0 1
4 00000088 00000000 000000c3 0 1
4 00000089 00000000 000000a5 0 1
4 0000008a 00000000 0000007e 0 1
4 0000008b 00000000 0000008f 0 1
1 00000088 00000000 ffffa5c3 0 1
1 0000008a 00000000 ffff8f7e 0 1
5 00000088 00000000 0000a5c3 0 1
5 0000008a 00000000 00008f7e 0 1
12 02000000 00000000 00000000 0 0
12 02000000 00000000 00000000 0 0
2 02000004 00000000 00000000 0 0
2 02000008 00000000 00000000 3 0
22 000000c0 000000a0 30304030 0 2
20 000000c5 000000e4 00000041 0 2
25 000000c6 000000fc 00003131 0 2
ff 00000000 00000000 00000000 0 0
